// File: decoder_pkg.sv
// Widths, opcode field types and control enums for the 6502 control decoder
// Opcode bytes that the decode stage treats as special cases
`default_nettype none

package decoder_pkg;

        localparam int reg_w = 8;
        localparam int we_w  = 6;

        typedef logic [reg_w-1:0] byte_t;
        typedef logic [2:0]       op_group_t;
        typedef logic [1:0]       column_t;
        typedef logic [we_w-1:0]  we_t;

        // Opcode bits 4..2
        typedef enum logic [2:0] {
                am_x_ind   = 3'd0,
                am_zpg     = 3'd1,
                am_imm_acc = 3'd2,
                am_abs     = 3'd3,
                am_ind_y   = 3'd4,
                am_zpg_x   = 3'd5,
                am_abs_y   = 3'd6,
                am_abs_x   = 3'd7
        } addr_mode_t;

        typedef enum logic [2:0] {
                no_op,
                op_or,
                op_and,
                op_xor,
                op_sum,
                op_sr
        } alu_op_t;

        // Data sources seen by the ALU inputs and the destination registers
        typedef enum logic [3:0] {
                sel_acc,
                sel_x,
                sel_y,
                sel_sp,
                sel_mem,
                sel_imm,
                sel_alu,
                sel_zero,
                sel_ff
        } sel_t;

        typedef enum logic [2:0] {
                kind_move,
                kind_alu_reg,
                kind_alu_mem,
                kind_none
        } insn_kind_t;

        // Write-enable bit positions
        localparam int we_acc  = 0;
        localparam int we_x    = 1;
        localparam int we_y    = 2;
        localparam int we_sp   = 3;
        localparam int we_stat = 4;
        localparam int we_dout = 5;

        localparam int carry_bit = 0;

        localparam byte_t opc_inx     = 8'hE8;
        localparam byte_t opc_iny     = 8'hC8;
        localparam byte_t opc_dex     = 8'hCA;
        localparam byte_t opc_dey     = 8'h88;
        localparam byte_t opc_txa     = 8'h8A;
        localparam byte_t opc_tya     = 8'h98;
        localparam byte_t opc_txs     = 8'h9A;
        localparam byte_t opc_tsx     = 8'hBA;
        localparam byte_t opc_ldy_imm = 8'hA0;
        localparam byte_t opc_ldx_imm = 8'hA2;
        localparam byte_t opc_cpy_imm = 8'hC0;
        localparam byte_t opc_cpx_imm = 8'hE0;

endpackage

`default_nettype wire

// File: decode_if.sv
// Decoded instruction bundle between the decode stage and the sequencer
`timescale 1ns/1ps
`default_nettype none

interface decode_if
        import decoder_pkg::*;
();
        logic       start;
        insn_kind_t kind;
        alu_op_t    alu_op;
        sel_t       alu0_sel;
        sel_t       alu1_sel;
        logic       use_status_carry;
        logic       fixed_carry;
        logic       invert_b;
        we_t        wb_we;
        sel_t       wb_sel;

        modport producer (
                output start, kind, alu_op, alu0_sel, alu1_sel,
                       use_status_carry, fixed_carry, invert_b, wb_we, wb_sel
        );

        modport consumer (
                input start, kind, alu_op, alu0_sel, alu1_sel,
                      use_status_carry, fixed_carry, invert_b, wb_we, wb_sel
        );

endinterface

`default_nettype wire

// File: instr_decode.sv
// Opcode capture and classification into kind, ALU controls and writeback targets
`timescale 1ns/1ps
`default_nettype none

module instr_decode
        import decoder_pkg::*;
(
        input  logic       clk,
        input  logic       reset_n,
        input  logic       instruction_ready,
        input  logic       busy,
        input  byte_t      instruction_in,
        decode_if.producer dec
);

        logic       capture;
        op_group_t  aaa;
        addr_mode_t mode;
        column_t    cc;
        sel_t       opnd;
        logic       step_x;
        logic       step_up;

        insn_kind_t kind;
        alu_op_t    alu_op;
        sel_t       alu0_sel;
        sel_t       alu1_sel;
        logic       use_status_carry;
        logic       fixed_carry;
        logic       invert_b;
        we_t        wb_we;
        sel_t       wb_sel;

        assign capture = instruction_ready && !busy;
        assign aaa     = instruction_in[7:5];
        assign mode    = addr_mode_t'(instruction_in[4:2]);
        assign cc      = instruction_in[1:0];

        // Register steps, INX and DEX work on X, INX and INY count up
        assign step_x  = instruction_in inside {opc_inx, opc_dex};
        assign step_up = instruction_in inside {opc_inx, opc_iny};

        always_comb begin
                case (mode)
                        am_imm_acc: opnd = instruction_in[0] ? sel_imm : sel_acc;
                        // Immediate loads and compares of column 00/10 sit in this slot
                        am_x_ind: begin
                                if (instruction_in inside {opc_ldy_imm, opc_ldx_imm,
                                                           opc_cpy_imm, opc_cpx_imm})
                                        opnd = sel_imm;
                                else
                                        opnd = sel_mem;
                        end
                        default: opnd = sel_mem;
                endcase
        end

        always_comb begin
                kind             = kind_none;
                alu_op           = no_op;
                alu0_sel         = sel_acc;
                alu1_sel         = opnd;
                use_status_carry = 1'b0;
                fixed_carry      = 1'b0;
                invert_b         = 1'b0;
                wb_we            = '0;
                wb_sel           = opnd;

                case (instruction_in)
                        opc_inx, opc_iny, opc_dex, opc_dey: begin
                                kind        = kind_alu_reg;
                                alu_op      = op_sum;
                                alu0_sel    = step_x ? sel_x : sel_y;
                                alu1_sel    = step_up ? sel_zero : sel_ff;
                                fixed_carry = step_up;
                                wb_sel      = sel_alu;
                                wb_we[we_stat] = 1'b1;
                                if (step_x)
                                        wb_we[we_x] = 1'b1;
                                else
                                        wb_we[we_y] = 1'b1;
                        end
                        opc_txa, opc_tya: begin
                                kind          = kind_move;
                                wb_we[we_acc] = 1'b1;
                                wb_sel        = instruction_in[4] ? sel_y : sel_x;
                        end
                        opc_txs: begin
                                kind         = kind_move;
                                wb_we[we_sp] = 1'b1;
                                wb_sel       = sel_x;
                        end
                        opc_tsx: begin
                                kind        = kind_move;
                                wb_we[we_x] = 1'b1;
                                wb_sel      = sel_sp;
                        end
                        default: begin
                                case ({cc, aaa})
                                        // STA, no immediate form
                                        5'b01_100: if (mode != am_imm_acc) begin
                                                kind           = kind_move;
                                                wb_we[we_dout] = 1'b1;
                                                wb_sel         = sel_acc;
                                        end
                                        5'b01_101: begin
                                                kind          = kind_move;
                                                wb_we[we_acc] = 1'b1;
                                        end
                                        5'b01_000, 5'b01_001, 5'b01_010, 5'b01_011,
                                        5'b01_110, 5'b01_111: begin
                                                kind           = kind_alu_reg;
                                                wb_sel         = sel_alu;
                                                wb_we[we_stat] = 1'b1;
                                                wb_we[we_acc]  = (aaa != 3'd6);
                                                case (aaa)
                                                        3'd0: alu_op = op_or;
                                                        3'd1: alu_op = op_and;
                                                        3'd2: alu_op = op_xor;
                                                        default: alu_op = op_sum;
                                                endcase
                                                // SBC borrows through the status carry, CMP does not
                                                invert_b         = aaa[2];
                                                use_status_carry = (aaa == 3'd3) || (aaa == 3'd7);
                                                fixed_carry      = (aaa == 3'd6);
                                        end
                                        5'b10_000, 5'b10_001, 5'b10_010, 5'b10_011:
                                        if (mode == am_imm_acc) begin
                                                kind             = kind_alu_reg;
                                                alu_op           = aaa[1] ? op_sr : op_sum;
                                                alu1_sel         = sel_acc;
                                                use_status_carry = aaa[0];
                                                wb_sel           = sel_alu;
                                                wb_we[we_acc]    = 1'b1;
                                                wb_we[we_stat]   = 1'b1;
                                        end
                                        5'b10_100, 5'b00_100:
                                        if (mode inside {am_zpg, am_abs, am_zpg_x}) begin
                                                kind           = kind_move;
                                                wb_we[we_dout] = 1'b1;
                                                wb_sel         = cc[1] ? sel_x : sel_y;
                                        end
                                        5'b10_101, 5'b00_101:
                                        if (!(mode inside {am_ind_y, am_abs_y})) begin
                                                kind = kind_move;
                                                if (cc[1])
                                                        wb_we[we_x] = 1'b1;
                                                else
                                                        wb_we[we_y] = 1'b1;
                                        end
                                        // DEC and INC on memory
                                        5'b10_110, 5'b10_111:
                                        if (mode inside {am_zpg, am_abs, am_zpg_x, am_abs_x}) begin
                                                kind           = kind_alu_mem;
                                                alu_op         = op_sum;
                                                alu0_sel       = sel_mem;
                                                alu1_sel       = aaa[0] ? sel_zero : sel_ff;
                                                fixed_carry    = aaa[0];
                                                wb_sel         = sel_alu;
                                                wb_we[we_dout] = 1'b1;
                                                wb_we[we_stat] = 1'b1;
                                        end
                                        // CPY and CPX
                                        5'b00_110, 5'b00_111:
                                        if (mode inside {am_x_ind, am_zpg, am_abs}) begin
                                                kind           = kind_alu_reg;
                                                alu_op         = op_sum;
                                                alu0_sel       = aaa[0] ? sel_x : sel_y;
                                                invert_b       = 1'b1;
                                                fixed_carry    = 1'b1;
                                                wb_sel         = sel_alu;
                                                wb_we[we_stat] = 1'b1;
                                        end
                                        default: ;
                                endcase
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n)
                        dec.start <= 1'b0;
                else
                        dec.start <= capture;
        end

        always_ff @(posedge clk) begin
                if (capture) begin
                        dec.kind             <= kind;
                        dec.alu_op           <= alu_op;
                        dec.alu0_sel         <= alu0_sel;
                        dec.alu1_sel         <= alu1_sel;
                        dec.use_status_carry <= use_status_carry;
                        dec.fixed_carry      <= fixed_carry;
                        dec.invert_b         <= invert_b;
                        dec.wb_we            <= wb_we;
                        dec.wb_sel           <= wb_sel;
                end
        end

endmodule

`default_nettype wire

// File: micro_sequencer.sv
// Issue and writeback FSM, ALU wait and destination selector registers
`timescale 1ns/1ps
`default_nettype none

module micro_sequencer
        import decoder_pkg::*;
(
        input  logic       clk,
        input  logic       reset_n,
        input  logic       alu_done,
        input  byte_t      status_in,
        decode_if.consumer dec,
        output logic       busy,
        output logic       instruction_done,
        output logic       carry_in,
        output logic       invert_alu_b,
        output alu_op_t    opp,
        output we_t        we,
        output sel_t       alu0_selector,
        output sel_t       alu1_selector,
        output sel_t       add_selector,
        output sel_t       x_selector,
        output sel_t       y_selector,
        output sel_t       sp_selector,
        output sel_t       mem_selector
);

        typedef enum logic [1:0] {
                st_idle,
                st_wait_alu,
                st_writeback
        } state_t;

        state_t state;
        logic   alu_kind;
        logic   issue;
        logic   wb_fire;

        assign alu_kind = dec.kind inside {kind_alu_reg, kind_alu_mem};
        assign issue    = dec.start && alu_kind;

        // Moves finish right at start, ALU work once the ALU reports done
        assign wb_fire = (dec.start && !alu_kind) || (state == st_wait_alu && alu_done);

        assign busy = dec.start || (state == st_wait_alu);

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        state            <= st_idle;
                        opp              <= no_op;
                        carry_in         <= 1'b0;
                        invert_alu_b     <= 1'b0;
                        we               <= '0;
                        instruction_done <= 1'b0;
                end else begin
                        we               <= wb_fire ? dec.wb_we : '0;
                        instruction_done <= wb_fire;
                        case (state)
                                st_wait_alu: begin
                                        if (alu_done) begin
                                                state        <= st_writeback;
                                                opp          <= no_op;
                                                carry_in     <= 1'b0;
                                                invert_alu_b <= 1'b0;
                                        end
                                end
                                default: begin
                                        if (issue) begin
                                                state        <= st_wait_alu;
                                                opp          <= dec.alu_op;
                                                invert_alu_b <= dec.invert_b;
                                                if (dec.use_status_carry)
                                                        carry_in <= status_in[carry_bit];
                                                else
                                                        carry_in <= dec.fixed_carry;
                                        end else if (wb_fire) begin
                                                state <= st_writeback;
                                        end else begin
                                                state <= st_idle;
                                        end
                                end
                        endcase
                end
        end

        // Selectors keep their last value between uses
        always_ff @(posedge clk) begin
                if (issue) begin
                        alu0_selector <= dec.alu0_sel;
                        alu1_selector <= dec.alu1_sel;
                end
                if (wb_fire) begin
                        if (dec.wb_we[we_acc])
                                add_selector <= dec.wb_sel;
                        if (dec.wb_we[we_x])
                                x_selector <= dec.wb_sel;
                        if (dec.wb_we[we_y])
                                y_selector <= dec.wb_sel;
                        if (dec.wb_we[we_sp])
                                sp_selector <= dec.wb_sel;
                        if (dec.wb_we[we_dout])
                                mem_selector <= dec.wb_sel;
                end
        end

endmodule

`default_nettype wire

// File: cpu_decoder.sv
// Top level of the 6502 control decoder, decode stage plus sequencer
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder
        import decoder_pkg::*;
(
        input  logic    clk,
        input  logic    reset_n,
        input  logic    instruction_ready,
        input  logic    alu_done,
        input  byte_t   instruction_in,
        input  byte_t   status_in,
        output alu_op_t opp,
        output logic    carry_in,
        output logic    invert_alu_b,
        output logic    instruction_done,
        output we_t     we,
        output sel_t    alu0_selector,
        output sel_t    alu1_selector,
        output sel_t    add_selector,
        output sel_t    x_selector,
        output sel_t    y_selector,
        output sel_t    sp_selector,
        output sel_t    mem_selector
);

        logic busy;

        decode_if dec_bus ();

        instr_decode u_decode (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .busy              (busy),
                .instruction_in    (instruction_in),
                .dec               (dec_bus)
        );

        micro_sequencer u_seq (
                .clk              (clk),
                .reset_n          (reset_n),
                .alu_done         (alu_done),
                .status_in        (status_in),
                .dec              (dec_bus),
                .busy             (busy),
                .instruction_done (instruction_done),
                .carry_in         (carry_in),
                .invert_alu_b     (invert_alu_b),
                .opp              (opp),
                .we               (we),
                .alu0_selector    (alu0_selector),
                .alu1_selector    (alu1_selector),
                .add_selector     (add_selector),
                .x_selector       (x_selector),
                .y_selector       (y_selector),
                .sp_selector      (sp_selector),
                .mem_selector     (mem_selector)
        );

endmodule

`default_nettype wire

// File: cpu_decoder_chk.sv
// Concurrent checks on top-level timing of the control decoder, bound to cpu_decoder
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder_chk
        import decoder_pkg::*;
(
        input logic    clk,
        input logic    reset_n,
        input logic    instruction_ready,
        input logic    busy,
        input logic    alu_done,
        input logic    instruction_done,
        input alu_op_t opp,
        input we_t     we
);

        logic       capture;
        logic [1:0] pending;

        assign capture = instruction_ready && !busy;

        // Accepted instructions that have not yet signalled done
        always_ff @(posedge clk) begin
                if (!reset_n)
                        pending <= '0;
                else
                        pending <= pending + 2'(capture) - 2'(instruction_done);
        end

        reset_quiet: assert property (@(posedge clk)
                $rose(reset_n) |-> we == '0 && !instruction_done && opp == no_op)
                else $error("outputs not idle after reset");

        done_single: assert property (@(posedge clk) disable iff (!reset_n)
                instruction_done |=> !instruction_done)
                else $error("instruction_done longer than one cycle");

        // Moves finish one cycle after capture, ALU work issues instead
        capture_timing: assert property (@(posedge clk) disable iff (!reset_n)
                capture |=> !instruction_done ##1 (instruction_done ^ (opp != no_op)))
                else $error("wrong response one cycle after capture");

        alu_hold: assert property (@(posedge clk) disable iff (!reset_n)
                opp != no_op && !alu_done |=> !instruction_done && $stable(opp))
                else $error("ALU controls changed before alu_done");

        alu_writeback: assert property (@(posedge clk) disable iff (!reset_n)
                opp != no_op && alu_done |=> instruction_done && opp == no_op)
                else $error("no writeback one cycle after alu_done");

        one_done: assert property (@(posedge clk) disable iff (!reset_n)
                instruction_done |-> pending == 2'd1)
                else $error("instruction_done without an accepted instruction");

endmodule

bind cpu_decoder cpu_decoder_chk u_chk (
        .clk               (clk),
        .reset_n           (reset_n),
        .instruction_ready (instruction_ready),
        .busy              (busy),
        .alu_done          (alu_done),
        .instruction_done  (instruction_done),
        .opp               (opp),
        .we                (we)
);

`default_nettype wire

// File: tb_cpu_decoder.sv
// Testbench for the control decoder with random kept opcodes and an ALU responder
// Reference rules give the expected issue controls, write enables and selectors
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_decoder
        import decoder_pkg::*;
();

        typedef enum int {
                m_ora, m_and, m_eor, m_adc, m_sbc, m_cmp, m_lda, m_sta,
                m_asl, m_rol, m_lsr, m_ror, m_inx, m_iny, m_dex, m_dey,
                m_inc, m_dec, m_cpx, m_cpy, m_ldx, m_ldy, m_stx, m_sty,
                m_txa, m_tya, m_txs, m_tsx, m_none
        } mnem_t;

        // Opcode with the addressing-mode bits clear, in mnem_t order
        byte_t base_tab [29] = '{
                8'h01, 8'h21, 8'h41, 8'h61, 8'hE1, 8'hC1, 8'hA1, 8'h81,
                8'h0A, 8'h2A, 8'h4A, 8'h6A, 8'hE8, 8'hC8, 8'hCA, 8'h88,
                8'hE2, 8'hC2, 8'hE0, 8'hC0, 8'hA2, 8'hA0, 8'h82, 8'h80,
                8'h8A, 8'h98, 8'h9A, 8'hBA, 8'h00
        };
        byte_t none_ops [6] = '{8'h00, 8'h18, 8'h08, 8'h4C, 8'h06, 8'hEA};

        logic    clk;
        logic    reset_n;
        logic    instruction_ready;
        logic    alu_done;
        byte_t   instruction_in;
        byte_t   status_in;
        alu_op_t opp;
        logic    carry_in;
        logic    invert_alu_b;
        logic    instruction_done;
        we_t     we;
        sel_t    alu0_selector;
        sel_t    alu1_selector;
        sel_t    add_selector;
        sel_t    x_selector;
        sel_t    y_selector;
        sel_t    sp_selector;
        sel_t    mem_selector;

        // Expected controls of the instruction in flight
        byte_t   cur_opc;
        logic    e_alu;
        alu_op_t e_op;
        sel_t    e_a0;
        sel_t    e_a1;
        sel_t    e_sel;
        logic    e_cin;
        logic    e_inv;
        we_t     e_we;

        cpu_decoder uut (.*);

        always #5 clk = ~clk;

        task automatic check_val(input string name, input int got, input int exp);
                assert (got == exp) else begin
                        $display("mismatch at %0t: %s is %0h, expected %0h (opcode %h)",
                                 $time, name, got, exp, cur_opc);
                        $display("Simulation failed");
                        $fatal(1, "value check failed");
                end
        endtask

        function automatic sel_t operand_source(input byte_t opc);
                case (opc[4:2])
                        3'd2: return opc[0] ? sel_imm : sel_acc;
                        3'd0: return (opc inside {8'hA0, 8'hA2, 8'hC0, 8'hE0}) ? sel_imm : sel_mem;
                        default: return sel_mem;
                endcase
        endfunction

        task automatic pick_instruction(output mnem_t m, output byte_t opc);
                logic [7:0] mask;
                logic [2:0] mode;
                m = mnem_t'($urandom_range(0, 28));
                case (m)
                        m_sta: mask = 8'hFB;
                        m_ora, m_and, m_eor, m_adc, m_sbc, m_cmp, m_lda: mask = 8'hFF;
                        m_ldx, m_ldy: mask = 8'hAB;
                        m_stx, m_sty: mask = 8'h2A;
                        m_inc, m_dec: mask = 8'hAA;
                        m_cpx, m_cpy: mask = 8'h0B;
                        default: mask = 8'h01;
                endcase
                // Random mode, moved up to the next one the instruction has
                mode = 3'($urandom_range(0, 7));
                for (int i = 0; i < 8 && !mask[mode]; i++)
                        mode = mode + 3'd1;
                opc = base_tab[m] | {3'b000, mode, 2'b00};
                if (m == m_none)
                        opc = none_ops[3'($urandom_range(0, 5))];
        endtask

        task automatic expect_for(input mnem_t m, input byte_t opc, input logic c);
                sel_t opnd;
                opnd  = operand_source(opc);
                e_alu = !(m inside {m_lda, m_ldx, m_ldy, m_sta, m_stx, m_sty,
                                    m_txa, m_tya, m_txs, m_tsx, m_none});
                e_op  = e_alu ? op_sum : no_op;
                e_a0  = sel_acc;
                e_a1  = opnd;
                e_cin = 1'b0;
                e_inv = m inside {m_sbc, m_cmp, m_cpx, m_cpy};
                e_sel = e_alu ? sel_alu : opnd;
                e_we  = '0;
                e_we[we_stat] = e_alu;
                case (m)
                        m_ora: e_op = op_or;
                        m_and: e_op = op_and;
                        m_eor: e_op = op_xor;
                        m_lsr, m_ror: e_op = op_sr;
                        default: ;
                endcase
                if (m inside {m_adc, m_sbc, m_rol, m_ror})
                        e_cin = c;
                if (m inside {m_cmp, m_cpx, m_cpy, m_inx, m_iny, m_inc})
                        e_cin = 1'b1;
                case (m)
                        m_asl, m_rol, m_lsr, m_ror: e_a1 = sel_acc;
                        m_inx, m_dex, m_cpx: e_a0 = sel_x;
                        m_iny, m_dey, m_cpy: e_a0 = sel_y;
                        m_inc, m_dec: e_a0 = sel_mem;
                        default: ;
                endcase
                if (m inside {m_inx, m_iny, m_inc})
                        e_a1 = sel_zero;
                if (m inside {m_dex, m_dey, m_dec})
                        e_a1 = sel_ff;
                case (m)
                        m_ora, m_and, m_eor, m_adc, m_sbc, m_asl, m_rol, m_lsr, m_ror,
                        m_lda, m_txa, m_tya: e_we[we_acc] = 1'b1;
                        m_inx, m_dex, m_ldx, m_tsx: e_we[we_x] = 1'b1;
                        m_iny, m_dey, m_ldy: e_we[we_y] = 1'b1;
                        m_txs: e_we[we_sp] = 1'b1;
                        m_inc, m_dec, m_sta, m_stx, m_sty: e_we[we_dout] = 1'b1;
                        default: ;
                endcase
                case (m)
                        m_sta: e_sel = sel_acc;
                        m_stx, m_txa, m_txs: e_sel = sel_x;
                        m_sty, m_tya: e_sel = sel_y;
                        m_tsx: e_sel = sel_sp;
                        default: ;
                endcase
        endtask

        task automatic check_issue();
                check_val("instruction_done", int'(instruction_done), 0);
                check_val("opp", int'(opp), int'(e_op));
                check_val("alu0_selector", int'(alu0_selector), int'(e_a0));
                check_val("alu1_selector", int'(alu1_selector), int'(e_a1));
                check_val("carry_in", int'(carry_in), int'(e_cin));
                check_val("invert_alu_b", int'(invert_alu_b), int'(e_inv));
        endtask

        task automatic check_dest();
                check_val("we", int'(we), int'(e_we));
                if (e_we[we_acc])
                        check_val("add_selector", int'(add_selector), int'(e_sel));
                if (e_we[we_x])
                        check_val("x_selector", int'(x_selector), int'(e_sel));
                if (e_we[we_y])
                        check_val("y_selector", int'(y_selector), int'(e_sel));
                if (e_we[we_sp])
                        check_val("sp_selector", int'(sp_selector), int'(e_sel));
                if (e_we[we_dout])
                        check_val("mem_selector", int'(mem_selector), int'(e_sel));
        endtask

        task automatic wait_done(output int cycles);
                cycles = 0;
                while (!instruction_done) begin
                        @(negedge clk);
                        alu_done          = 1'b0;
                        instruction_ready = 1'b0;
                        cycles++;
                        if (cycles > 50) begin
                                $display("timeout: instruction_done did not arrive in 50 cycles");
                                $display("Simulation failed");
                                $fatal(1, "timeout");
                        end
                end
        endtask

        task automatic run_instruction();
                mnem_t m;
                byte_t opc;
                logic  c;
                int    delay;
                int    cycles;
                pick_instruction(m, opc);
                c = 1'($urandom_range(0, 1));
                expect_for(m, opc, c);
                cur_opc = opc;
                @(negedge clk);
                instruction_ready    = 1'b1;
                instruction_in       = opc;
                status_in            = 8'($urandom);
                status_in[carry_bit] = c;
                @(negedge clk);
                instruction_ready = 1'b0;
                @(negedge clk);
                if (!e_alu) begin
                        check_val("instruction_done", int'(instruction_done), 1);
                        check_dest();
                end else begin
                        check_issue();
                        // A strobe during the ALU wait must be dropped
                        instruction_ready = 1'b1;
                        instruction_in    = 8'($urandom);
                        delay = $urandom_range(1, 4);
                        for (int i = 1; i < delay; i++) begin
                                @(negedge clk);
                                instruction_ready = 1'b0;
                                check_issue();
                        end
                        alu_done = 1'b1;
                        wait_done(cycles);
                        check_val("alu_done to instruction_done cycles", cycles, 1);
                        check_val("opp", int'(opp), int'(no_op));
                        check_dest();
                end
        endtask

        initial begin
                void'($urandom(32'hc049_e5fc));
                clk               = 1'b0;
                reset_n           = 1'b0;
                instruction_ready = 1'b0;
                alu_done          = 1'b0;
                instruction_in    = '0;
                status_in         = '0;
                cur_opc           = '0;
                repeat (3) @(posedge clk);
                @(negedge clk);
                reset_n = 1'b1;
                for (int n = 0; n < 400; n++)
                        run_instruction();
                $display("Simulation passed");
                $finish;
        end

endmodule

`default_nettype wire

// File: src.f
decoder_pkg.sv
decode_if.sv
instr_decode.sv
micro_sequencer.sv
cpu_decoder.sv
cpu_decoder_chk.sv
tb_cpu_decoder.sv

// File: run.sh
#!/bin/sh
# Compile the testbench with Verilator and run it, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_cpu_decoder -f src.f -o tb_cpu_decoder &&
./obj_dir/tb_cpu_decoder || exit 1
